//--- source/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;

    // values of Cause.ExcCode
    typedef enum logic [4:0] {
        INT  = 5'd0,
        MOD  = 5'd1,
        TLBL = 5'd2,
        TLBS = 5'd3,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        CPU  = 5'd11,
        OV   = 5'd12,
        TR   = 5'd13
    } exc_code_e;

    // flag vector bit indices, highest priority first
    typedef enum logic [3:0] {
        FLAG_ADEL_IF,
        FLAG_TLBL_IF,
        FLAG_CPU,
        FLAG_RI,
        FLAG_OV,
        FLAG_BP,
        FLAG_SYS,
        FLAG_TR,
        FLAG_ADEL_LD,
        FLAG_ADES,
        FLAG_TLBL_LD,
        FLAG_TLBS,
        FLAG_MOD
    } exc_flag_e;

    localparam int EXC_FLAG_W = 13;

    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14
    } cp0_reg_e;

    // Status fields
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_ERL   = 2;
    localparam int STATUS_IM_LO = 8;
    localparam int STATUS_IM_HI = 15;
    localparam int STATUS_BEV   = 22;

    // Cause fields
    localparam int CAUSE_EXC_LO = 2;
    localparam int CAUSE_EXC_HI = 6;
    localparam int CAUSE_IP_LO  = 8;
    localparam int CAUSE_IP_HI  = 15;
    localparam int CAUSE_BD     = 31;

    // boot state keeps interrupts off until ERL is cleared
    localparam word_t STATUS_RESET = (word_t'(1) << STATUS_BEV) | (word_t'(1) << STATUS_ERL);

    // IE, EXL, ERL and IM
    localparam word_t STATUS_WMASK = 32'h0000_ff07;

endpackage

`default_nettype wire

//--- source/exception.sv
`timescale 1ns/1ps
`default_nettype none

module exception #(
    parameter mips_pkg::word_t EXC_VECTOR    = 32'hbfc0_0380,
    parameter mips_pkg::word_t REFILL_VECTOR = 32'hbfc0_0200
) (
    input  wire logic                            commit_valid,
    input  wire logic [mips_pkg::EXC_FLAG_W-1:0] exc_flags,
    input  wire logic                            tlb_refill,
    input  wire mips_pkg::word_t                 status,
    input  wire mips_pkg::word_t                 cause,
    output logic                                 exception_valid,
    output mips_pkg::exc_code_e                  exception_code,
    output mips_pkg::word_t                      exception_target,
    output logic                                 exc_vaddr_valid
);

    import mips_pkg::*;

    logic      int_pending;
    logic      tlb_cause;
    logic      use_refill;
    exc_code_e flag_code;

    // interrupt request gated by IE, EXL and ERL
    assign int_pending = (|(cause[CAUSE_IP_HI:CAUSE_IP_LO] & status[STATUS_IM_HI:STATUS_IM_LO]))
                       & status[STATUS_IE]
                       & ~status[STATUS_EXL]
                       & ~status[STATUS_ERL];

    // lowest set flag index wins
    always_comb begin
        priority case (1'b1)
            exc_flags[FLAG_ADEL_IF]: flag_code = ADEL;
            exc_flags[FLAG_TLBL_IF]: flag_code = TLBL;
            exc_flags[FLAG_CPU]:     flag_code = CPU;
            exc_flags[FLAG_RI]:      flag_code = RI;
            exc_flags[FLAG_OV]:      flag_code = OV;
            exc_flags[FLAG_BP]:      flag_code = BP;
            exc_flags[FLAG_SYS]:     flag_code = SYS;
            exc_flags[FLAG_TR]:      flag_code = TR;
            exc_flags[FLAG_ADEL_LD]: flag_code = ADEL;
            exc_flags[FLAG_ADES]:    flag_code = ADES;
            exc_flags[FLAG_TLBL_LD]: flag_code = TLBL;
            exc_flags[FLAG_TLBS]:    flag_code = TLBS;
            exc_flags[FLAG_MOD]:     flag_code = MOD;
            default:                 flag_code = INT;
        endcase
    end

    assign exception_valid = commit_valid & (int_pending | (|exc_flags));

    // interrupts outrank every flag
    assign exception_code = int_pending ? INT : flag_code;

    // only TLB load/store misses may go to the refill entry
    assign tlb_cause = (exception_code == TLBL) || (exception_code == TLBS);

    // nested misses while EXL is set take the general vector
    assign use_refill = tlb_cause & tlb_refill & ~status[STATUS_EXL];

    assign exception_target = use_refill ? REFILL_VECTOR : EXC_VECTOR;

    // causes that load BadVAddr
    assign exc_vaddr_valid = exception_code inside {ADEL, ADES, TLBL, TLBS, MOD};

endmodule

`default_nettype wire

//--- source/interrupt_sync.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_sync (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic [5:0] ext_int,
    output logic      [5:0] hw_ip
);

    // first stage may go metastable
    logic [5:0] ext_int_meta;

    // two flops per device line, lines are independent
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ext_int_meta <= '0;
            hw_ip        <= '0;
        end else begin
            ext_int_meta <= ext_int;
            hw_ip        <= ext_int_meta;
        end
    end

endmodule

`default_nettype wire

//--- source/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic          [5:0] hw_ip,
    input  wire logic                exception_valid,
    input  wire mips_pkg::exc_code_e exception_code,
    input  wire logic                exc_vaddr_valid,
    input  wire mips_pkg::word_t     commit_pc,
    input  wire mips_pkg::word_t     commit_vaddr,
    input  wire logic                in_delay_slot,
    input  wire logic                eret,
    input  wire logic                cp0_we,
    input  wire logic          [4:0] cp0_waddr,
    input  wire mips_pkg::word_t     cp0_wdata,
    input  wire logic          [4:0] cp0_raddr,
    output mips_pkg::word_t          status,
    output mips_pkg::word_t          cause,
    output mips_pkg::word_t          epc,
    output mips_pkg::word_t          cp0_rdata
);

    import mips_pkg::*;

    word_t     status_q;
    word_t     status_next;
    word_t     epc_q;
    word_t     badvaddr_q;
    exc_code_e cause_exc;
    logic      cause_bd;
    logic [1:0] ip_sw;
    logic      first_level;
    logic      wr_status;
    logic      wr_cause;
    logic      wr_epc;

    assign wr_status = cp0_we && (cp0_waddr == STATUS);
    assign wr_cause  = cp0_we && (cp0_waddr == CAUSE);
    assign wr_epc    = cp0_we && (cp0_waddr == EPC);

    // EPC and BD only follow the outermost exception
    assign first_level = exception_valid & ~status_q[STATUS_EXL];

    // lowest priority first, later lines override
    always_comb begin
        status_next = status_q;
        if (wr_status) begin
            status_next = (status_q & ~STATUS_WMASK) | (cp0_wdata & STATUS_WMASK);
        end
        if (eret) begin
            status_next[STATUS_EXL] = 1'b0;
        end
        if (exception_valid) begin
            status_next[STATUS_EXL] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= STATUS_RESET;
        end else begin
            status_q <= status_next;
        end
    end

    // Cause.ExcCode, Cause.BD and the software IP bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cause_exc <= INT;
            cause_bd  <= 1'b0;
            ip_sw     <= 2'b00;
        end else begin
            if (exception_valid) begin
                cause_exc <= exception_code;
            end
            if (first_level) begin
                cause_bd <= in_delay_slot;
            end
            if (wr_cause) begin
                ip_sw <= cp0_wdata[CAUSE_IP_LO+1:CAUSE_IP_LO];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            epc_q      <= '0;
            badvaddr_q <= '0;
        end else begin
            if (first_level) begin
                // delay slot restarts at the branch
                epc_q <= in_delay_slot ? (commit_pc - 32'd4) : commit_pc;
            end else if (wr_epc) begin
                epc_q <= cp0_wdata;
            end
            if (exception_valid && exc_vaddr_valid) begin
                badvaddr_q <= commit_vaddr;
            end
        end
    end

    // hardware IP bits come straight from the synchronizer
    assign cause = {cause_bd, 15'b0, hw_ip, ip_sw, 1'b0, cause_exc, 2'b00};
    assign status = status_q;
    assign epc = epc_q;

    // mfc0 read port
    always_comb begin
        case (cp0_raddr)
            BADVADDR: cp0_rdata = badvaddr_q;
            STATUS:   cp0_rdata = status_q;
            CAUSE:    cp0_rdata = cause;
            EPC:      cp0_rdata = epc_q;
            default:  cp0_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/exception_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exception_unit #(
    parameter mips_pkg::word_t EXC_VECTOR    = 32'hbfc0_0380,
    parameter mips_pkg::word_t REFILL_VECTOR = 32'hbfc0_0200
) (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                      [5:0] ext_int,
    input  wire logic                            commit_valid,
    input  wire logic [mips_pkg::EXC_FLAG_W-1:0] exc_flags,
    input  wire logic                            tlb_refill,
    input  wire mips_pkg::word_t                 commit_pc,
    input  wire mips_pkg::word_t                 commit_vaddr,
    input  wire logic                            in_delay_slot,
    input  wire logic                            eret,
    input  wire logic                            cp0_we,
    input  wire logic                      [4:0] cp0_waddr,
    input  wire mips_pkg::word_t                 cp0_wdata,
    input  wire logic                      [4:0] cp0_raddr,
    output logic                                 exception_valid,
    output mips_pkg::exc_code_e                  exception_code,
    output mips_pkg::word_t                      exception_target,
    output mips_pkg::word_t                      epc,
    output mips_pkg::word_t                      cp0_rdata
);

    import mips_pkg::*;

    logic [5:0] hw_ip;
    word_t      status;
    word_t      cause;
    logic       exc_vaddr_valid;

    interrupt_sync u_interrupt_sync (
        .clk     (clk),
        .rst_n   (rst_n),
        .ext_int (ext_int),
        .hw_ip   (hw_ip)
    );

    exception #(
        .EXC_VECTOR    (EXC_VECTOR),
        .REFILL_VECTOR (REFILL_VECTOR)
    ) u_exception (
        .commit_valid     (commit_valid),
        .exc_flags        (exc_flags),
        .tlb_refill       (tlb_refill),
        .status           (status),
        .cause            (cause),
        .exception_valid  (exception_valid),
        .exception_code   (exception_code),
        .exception_target (exception_target),
        .exc_vaddr_valid  (exc_vaddr_valid)
    );

    // commit info goes straight to CP0 for capture
    cp0_regs u_cp0_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .hw_ip           (hw_ip),
        .exception_valid (exception_valid),
        .exception_code  (exception_code),
        .exc_vaddr_valid (exc_vaddr_valid),
        .commit_pc       (commit_pc),
        .commit_vaddr    (commit_vaddr),
        .in_delay_slot   (in_delay_slot),
        .eret            (eret),
        .cp0_we          (cp0_we),
        .cp0_waddr       (cp0_waddr),
        .cp0_wdata       (cp0_wdata),
        .cp0_raddr       (cp0_raddr),
        .status          (status),
        .cause           (cause),
        .epc             (epc),
        .cp0_rdata       (cp0_rdata)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset low for the first 4 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/exception_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exception_tb;

    import mips_pkg::*;

    logic clk, rst_n, commit_valid, tlb_refill, in_delay_slot, eret, cp0_we;
    logic [5:0] ext_int;
    logic [EXC_FLAG_W-1:0] exc_flags;
    logic [4:0] cp0_waddr, cp0_raddr;
    word_t commit_pc, commit_vaddr, cp0_wdata, exception_target, epc, cp0_rdata;
    logic exception_valid;
    exc_code_e exception_code;
    // testbench copies of Status and the Cause.IP field
    word_t shadow_status, shadow_cause;
    logic [31:0] lcg_state;
    int errors, checks, tests, test_mark;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    exception_unit UUT (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected {valid, code, target} for a commit with commit_valid high
    function automatic logic [37:0] ref_exception(input logic [12:0] flags, input logic refill,
                                                  input word_t st, input word_t ca);
        logic pend;
        logic [4:0] code;
        word_t target;
        pend = (|(ca[15:8] & st[15:8])) && st[0] && !st[1] && !st[2];
        code = 5'd0;
        // walk down so the lowest set index is taken last
        for (int i = EXC_FLAG_W - 1; i >= 0; i--) begin
            if (flags[i] && !pend) begin
                case (i)
                    FLAG_ADEL_IF, FLAG_ADEL_LD: code = 5'd4;
                    FLAG_TLBL_IF, FLAG_TLBL_LD: code = 5'd2;
                    FLAG_CPU:  code = 5'd11;
                    FLAG_RI:   code = 5'd10;
                    FLAG_OV:   code = 5'd12;
                    FLAG_BP:   code = 5'd9;
                    FLAG_SYS:  code = 5'd8;
                    FLAG_TR:   code = 5'd13;
                    FLAG_ADES: code = 5'd5;
                    FLAG_TLBS: code = 5'd3;
                    default:   code = 5'd1;
                endcase
            end
        end
        target = ((code == 5'd2 || code == 5'd3) && refill && !st[1]) ? 32'hbfc0_0200
                                                                       : 32'hbfc0_0380;
        return {pend || (|flags), code, target};
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-10s %s", name, (errors == test_mark) ? "ok" : "has errors");
        test_mark = errors;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic mtc0(input logic [4:0] addr, input word_t data);
        cp0_we = 1'b1;
        cp0_waddr = addr;
        cp0_wdata = data;
        step();
        cp0_we = 1'b0;
        if (addr == STATUS) shadow_status = (shadow_status & ~STATUS_WMASK) | (data & STATUS_WMASK);
        if (addr == CAUSE) shadow_cause[9:8] = data[9:8];
    endtask

    task automatic mfc0(input logic [4:0] addr, output word_t data);
        cp0_raddr = addr;
        #1;
        data = cp0_rdata;
        step();
    endtask

    // one committing instruction, outputs compared mid-cycle
    task automatic commit(input string name, input logic [12:0] flags, input logic refill,
                          input word_t pc, input word_t vaddr, input logic ds);
        logic [37:0] exp;
        commit_valid = 1'b1;
        exc_flags = flags;
        tlb_refill = refill;
        commit_pc = pc;
        commit_vaddr = vaddr;
        in_delay_slot = ds;
        #1;
        exp = ref_exception(flags, refill, shadow_status, shadow_cause);
        check_value({name, " valid"}, exp[37], exception_valid);
        check_value({name, " code"}, exp[36:32], exception_code);
        check_value({name, " target"}, exp[31:0], exception_target);
        step();
        commit_valid = 1'b0;
        exc_flags = '0;
        if (exp[37]) shadow_status[STATUS_EXL] = 1'b1;
    endtask

    initial begin
        word_t r, pc, va, rd;
        logic seen;
        {commit_valid, tlb_refill, in_delay_slot, eret, cp0_we} = '0;
        ext_int = '0;
        exc_flags = '0;
        {cp0_waddr, cp0_raddr} = '0;
        {commit_pc, commit_vaddr, cp0_wdata} = '0;
        lcg_state = 32'h3959_48d7;
        {errors, checks, tests, test_mark} = '0;
        shadow_status = STATUS_RESET;
        shadow_cause = '0;
        for (int i = 0; i < 20 && rst_n !== 1'b1; i++) @(posedge clk);
        if (rst_n !== 1'b1) begin
            errors++;
            $display("reset was never released");
        end
        #1;

        mfc0(STATUS, rd);
        check_value("reset status", STATUS_RESET, rd);
        mfc0(CAUSE, rd);
        check_value("reset cause", 0, rd);
        mfc0(EPC, rd);
        check_value("reset epc", 0, rd);
        mfc0(BADVADDR, rd);
        check_value("reset badvaddr", 0, rd);
        // IE and every IM bit on, ERL still set from reset
        mtc0(STATUS, 32'h0000_ff05);
        ext_int = 6'h3f;
        commit_valid = 1'b1;
        for (int i = 0; i < 6; i++) begin
            step();
            check_value("erl blocks int", 0, exception_valid);
        end
        commit_valid = 1'b0;
        ext_int = '0;
        repeat (3) step();
        end_test("reset");

        mtc0(STATUS, 32'h0);
        for (int n = 0; n < 200; n++) begin
            r = lcg_next();
            pc = lcg_next();
            va = lcg_next();
            // random shift spreads the winning index over all flags
            commit("random", r[28:16] << r[11:8], r[31], {pc[31:2], 2'b00}, va, r[7]);
            if (shadow_status[STATUS_EXL]) mtc0(STATUS, shadow_status & ~32'h2);
        end
        end_test("priority");

        // delay slot load of a store address error
        commit("ades", 13'd1 << FLAG_ADES, 1'b0, 32'h8000_1000, 32'h1234_5678, 1'b1);
        mfc0(EPC, rd);
        check_value("ds epc", 32'h8000_0ffc, rd);
        mfc0(CAUSE, rd);
        check_value("ds bd", 1, rd[31]);
        check_value("ds code", ADES, rd[6:2]);
        mfc0(BADVADDR, rd);
        check_value("ds badvaddr", 32'h1234_5678, rd);
        mtc0(STATUS, 32'h0);
        commit("ov", 13'd1 << FLAG_OV, 1'b0, 32'h8000_2000, 32'hdead_beef, 1'b0);
        mfc0(EPC, rd);
        check_value("ov epc", 32'h8000_2000, rd);
        mfc0(CAUSE, rd);
        check_value("ov bd", 0, rd[31]);
        check_value("ov code", OV, rd[6:2]);
        mfc0(BADVADDR, rd);
        check_value("ov badvaddr kept", 32'h1234_5678, rd);
        // nested refill while EXL is still set
        commit("nested", 13'd1 << FLAG_TLBL_LD, 1'b1, 32'h8000_3000, 32'h0000_4000, 1'b0);
        mfc0(EPC, rd);
        check_value("nested epc", 32'h8000_2000, rd);
        end_test("capture");

        check_value("epc port", 32'h8000_2000, epc);
        eret = 1'b1;
        step();
        eret = 1'b0;
        shadow_status[STATUS_EXL] = 1'b0;
        mfc0(STATUS, rd);
        check_value("eret status", shadow_status, rd);
        end_test("eret");

        // ext_int[0] lands on Cause.IP2, enabled by IM2
        mtc0(STATUS, 32'h0000_0401);
        ext_int = 6'h01;
        commit_valid = 1'b1;
        seen = 1'b0;
        for (int i = 0; i < 10 && !seen; i++) begin
            step();
            seen = exception_valid;
        end
        if (!seen) begin
            errors++;
            $display("timeout waiting for the external interrupt exception");
        end
        // a flag in the same cycle must not displace the interrupt
        exc_flags = 13'd1 << FLAG_RI;
        #1;
        check_value("ext int valid", 1, exception_valid);
        check_value("ext int code", INT, exception_code);
        step();
        commit_valid = 1'b0;
        exc_flags = '0;
        shadow_status[STATUS_EXL] = 1'b1;
        mtc0(STATUS, 32'h0000_0001);
        commit_valid = 1'b1;
        for (int i = 0; i < 8; i++) begin
            step();
            check_value("masked int", 0, exception_valid);
        end
        commit_valid = 1'b0;
        ext_int = '0;
        repeat (3) step();
        end_test("ext_int");

        mtc0(STATUS, 32'h0000_0101);
        mtc0(CAUSE, 32'h0000_0100);
        commit("sw int", 13'd1 << FLAG_SYS, 1'b0, 32'h8000_5000, 32'h0, 1'b0);
        mtc0(STATUS, 32'h0);
        mtc0(CAUSE, 32'h0);
        end_test("sw_int");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/mips_pkg.sv
source/exception.sv
source/interrupt_sync.sv
source/cp0_regs.sv
source/exception_unit.sv
verification/tb_clock.sv
verification/exception_tb.sv
